/* verilog/mem_sched_pkg.sv */
package mem_sched_pkg;

    // request payload
    typedef logic [15:0] data_t;
    typedef logic [6:0]  idx_t;

    // address fields
    typedef logic [15:0] row_t;
    typedef logic [9:0]  col_t;
    typedef logic [1:0]  bank_t;
    typedef logic [1:0]  group_t;

    // flat address, from the top: row, bank, group, column
    typedef logic [29:0] addr_t;

    // group * 4 + bank
    typedef logic [3:0]  bank_id_t;

    localparam int N_GROUPS = 4;
    localparam int N_BANKS  = 4;
    localparam int N_SLOTS  = N_GROUPS * N_BANKS;

    // field positions inside addr_t
    localparam int COL_LSB   = 0;
    localparam int GROUP_LSB = COL_LSB + $bits(col_t);
    localparam int BANK_LSB  = GROUP_LSB + $bits(group_t);
    localparam int ROW_LSB   = BANK_LSB + $bits(bank_t);

    typedef enum logic {
        ARB_IDLE,
        ARB_GRANT
    } arb_state_t;

endpackage

/* verilog/req_decode.sv */
module req_decode (
    input  logic                                               clk_i,
    input  logic                                               rst_i,
    input  logic                                               req_valid_i,
    input  mem_sched_pkg::addr_t                               req_addr_i,
    input  mem_sched_pkg::data_t                               req_data_i,
    input  mem_sched_pkg::idx_t                                req_idx_i,
    input  logic                                               grant_i,
    input  mem_sched_pkg::bank_id_t                            grant_bank_i,
    output logic                  [mem_sched_pkg::N_SLOTS-1:0] pending_o,
    output mem_sched_pkg::data_t  [mem_sched_pkg::N_SLOTS-1:0] slot_data_o,
    output mem_sched_pkg::idx_t   [mem_sched_pkg::N_SLOTS-1:0] slot_idx_o,
    output mem_sched_pkg::row_t   [mem_sched_pkg::N_SLOTS-1:0] slot_row_o,
    output mem_sched_pkg::col_t   [mem_sched_pkg::N_SLOTS-1:0] slot_col_o,
    output logic                                               drop_o
);

    mem_sched_pkg::row_t     req_row;
    mem_sched_pkg::col_t     req_col;
    mem_sched_pkg::bank_t    req_bank;
    mem_sched_pkg::group_t   req_group;
    mem_sched_pkg::bank_id_t req_slot;
    logic                    slot_busy;
    logic                    accept;

    // address split
    assign req_row   = req_addr_i[mem_sched_pkg::ROW_LSB +: $bits(mem_sched_pkg::row_t)];
    assign req_bank  = req_addr_i[mem_sched_pkg::BANK_LSB +: $bits(mem_sched_pkg::bank_t)];
    assign req_group = req_addr_i[mem_sched_pkg::GROUP_LSB +: $bits(mem_sched_pkg::group_t)];
    assign req_col   = req_addr_i[mem_sched_pkg::COL_LSB +: $bits(mem_sched_pkg::col_t)];
    assign req_slot  = {req_group, req_bank};

    // a slot being granted on this edge still counts as busy
    assign slot_busy = pending_o[req_slot];
    assign accept    = req_valid_i && !slot_busy;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_o <= '0;
            drop_o    <= 1'b0;
        end else begin
            drop_o <= req_valid_i && slot_busy;
            if (grant_i) begin
                pending_o[grant_bank_i] <= 1'b0;
            end
            if (accept) begin
                pending_o[req_slot] <= 1'b1;
            end
        end
    end

    // slot payload, only written into an empty slot
    always_ff @(posedge clk_i) begin
        if (accept) begin
            slot_data_o[req_slot] <= req_data_i;
            slot_idx_o[req_slot]  <= req_idx_i;
            slot_row_o[req_slot]  <= req_row;
            slot_col_o[req_slot]  <= req_col;
        end
    end

    // the arbiter only grants slots that hold a request
    a_grant_pending : assert property (
        @(posedge clk_i) disable iff (rst_i)
        grant_i |-> pending_o[grant_bank_i]
    );

endmodule

/* verilog/bank_arbiter.sv */
module bank_arbiter #(
    parameter int BANK_GAP = 1
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic                   [mem_sched_pkg::N_SLOTS-1:0] pending_i,
    output mem_sched_pkg::bank_t   [mem_sched_pkg::N_GROUPS-1:0] bank_sel_o,
    output mem_sched_pkg::group_t                               group_sel_o,
    output logic                                                grant_o,
    output mem_sched_pkg::bank_id_t                             grant_bank_o
);

    localparam int CNT_W = $clog2(BANK_GAP + 1);

    mem_sched_pkg::arb_state_t                                state;
    mem_sched_pkg::group_t                                    group_ptr;
    mem_sched_pkg::bank_t     [mem_sched_pkg::N_GROUPS-1:0]   bank_ptr;
    logic                     [mem_sched_pkg::N_SLOTS-1:0][CNT_W-1:0] gap_cnt;

    logic                     [mem_sched_pkg::N_SLOTS-1:0]    eligible;
    logic                     [mem_sched_pkg::N_GROUPS-1:0]   grp_elig;
    logic                                                     any_elig;
    mem_sched_pkg::group_t                                    win_grp;
    mem_sched_pkg::bank_t                                     win_bank;
    mem_sched_pkg::bank_id_t                                  win_id;

    always_comb begin
        for (int k = 0; k < mem_sched_pkg::N_SLOTS; k++) begin
            eligible[k] = pending_i[k] && (gap_cnt[k] == '0);
        end
        for (int g = 0; g < mem_sched_pkg::N_GROUPS; g++) begin
            grp_elig[g] = |eligible[g*mem_sched_pkg::N_BANKS +: mem_sched_pkg::N_BANKS];
        end
        any_elig = |eligible;
    end

    // first eligible group at or after the group pointer
    always_comb begin : pick_group
        mem_sched_pkg::group_t cand;
        logic                  found;
        win_grp = group_ptr;
        found   = 1'b0;
        for (int i = 0; i < mem_sched_pkg::N_GROUPS; i++) begin
            cand = mem_sched_pkg::group_t'(group_ptr + i);
            if (!found && grp_elig[cand]) begin
                win_grp = cand;
                found   = 1'b1;
            end
        end
    end

    // then the first eligible bank of that group, from its own pointer
    always_comb begin : pick_bank
        mem_sched_pkg::bank_t cand;
        logic                 found;
        win_bank = bank_ptr[win_grp];
        found    = 1'b0;
        for (int i = 0; i < mem_sched_pkg::N_BANKS; i++) begin
            cand = mem_sched_pkg::bank_t'(bank_ptr[win_grp] + i);
            if (!found && eligible[{win_grp, cand}]) begin
                win_bank = cand;
                found    = 1'b1;
            end
        end
    end

    assign win_id  = {win_grp, win_bank};
    assign grant_o = (state == mem_sched_pkg::ARB_GRANT);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= mem_sched_pkg::ARB_IDLE;
            group_ptr    <= '0;
            bank_ptr     <= '0;
            gap_cnt      <= '0;
            bank_sel_o   <= '0;
            group_sel_o  <= '0;
            grant_bank_o <= '0;
        end else begin
            state <= any_elig ? mem_sched_pkg::ARB_GRANT : mem_sched_pkg::ARB_IDLE;
            for (int k = 0; k < mem_sched_pkg::N_SLOTS; k++) begin
                if (gap_cnt[k] != '0) begin
                    gap_cnt[k] <= gap_cnt[k] - 1'b1;
                end
            end
            if (any_elig) begin
                // winner reload overrides its own countdown
                gap_cnt[win_id]     <= CNT_W'(BANK_GAP);
                group_ptr           <= win_grp + 1'b1;
                bank_ptr[win_grp]   <= win_bank + 1'b1;
                bank_sel_o[win_grp] <= win_bank;
                group_sel_o         <= win_grp;
                grant_bank_o        <= win_id;
            end
        end
    end

    // no bank is granted twice within BANK_GAP cycles
    for (genvar d = 1; d <= BANK_GAP; d++) begin : g_gap
        a_gap_done : assert property (
            @(posedge clk_i) disable iff (rst_i)
            grant_o && $past(grant_o, d) |-> grant_bank_o != $past(grant_bank_o, d)
        );
    end

    a_grant_sel : assert property (
        @(posedge clk_i) disable iff (rst_i)
        grant_o |-> grant_bank_o == {group_sel_o, bank_sel_o[group_sel_o]}
    );

endmodule

/* verilog/data_path.sv */
module data_path (
    input  mem_sched_pkg::data_t  [mem_sched_pkg::N_SLOTS-1:0]  data_i,
    input  mem_sched_pkg::idx_t   [mem_sched_pkg::N_SLOTS-1:0]  idx_i,
    input  mem_sched_pkg::row_t   [mem_sched_pkg::N_SLOTS-1:0]  row_i,
    input  mem_sched_pkg::col_t   [mem_sched_pkg::N_SLOTS-1:0]  col_i,
    input  mem_sched_pkg::bank_t  [mem_sched_pkg::N_GROUPS-1:0] bank_sel_i,
    input  mem_sched_pkg::group_t                               group_sel_i,
    output mem_sched_pkg::data_t                                data_o,
    output mem_sched_pkg::idx_t                                 idx_o,
    output mem_sched_pkg::row_t                                 row_o,
    output mem_sched_pkg::col_t                                 col_o,
    output mem_sched_pkg::bank_t                                ba_o,
    output mem_sched_pkg::group_t                               bg_o
);

    // one candidate per group after the first level
    mem_sched_pkg::data_t grp_data [mem_sched_pkg::N_GROUPS];
    mem_sched_pkg::idx_t  grp_idx  [mem_sched_pkg::N_GROUPS];
    mem_sched_pkg::row_t  grp_row  [mem_sched_pkg::N_GROUPS];
    mem_sched_pkg::col_t  grp_col  [mem_sched_pkg::N_GROUPS];
    mem_sched_pkg::bank_t grp_ba   [mem_sched_pkg::N_GROUPS];

    // bank select inside each group
    always_comb begin : bank_level
        mem_sched_pkg::bank_id_t slot;
        for (int g = 0; g < mem_sched_pkg::N_GROUPS; g++) begin
            slot        = {mem_sched_pkg::group_t'(g), bank_sel_i[g]};
            grp_data[g] = data_i[slot];
            grp_idx[g]  = idx_i[slot];
            grp_row[g]  = row_i[slot];
            grp_col[g]  = col_i[slot];
            grp_ba[g]   = bank_sel_i[g];
        end
    end

    // group select
    always_comb begin
        data_o = grp_data[group_sel_i];
        idx_o  = grp_idx[group_sel_i];
        row_o  = grp_row[group_sel_i];
        col_o  = grp_col[group_sel_i];
        ba_o   = grp_ba[group_sel_i];
        bg_o   = group_sel_i;
    end

endmodule

/* verilog/cmd_issue.sv */
module cmd_issue (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  grant_i,
    input  mem_sched_pkg::data_t  data_i,
    input  mem_sched_pkg::idx_t   idx_i,
    input  mem_sched_pkg::row_t   row_i,
    input  mem_sched_pkg::col_t   col_i,
    input  mem_sched_pkg::bank_t  ba_i,
    input  mem_sched_pkg::group_t bg_i,
    output logic                  cmd_valid_o,
    output mem_sched_pkg::data_t  cmd_data_o,
    output mem_sched_pkg::idx_t   cmd_idx_o,
    output mem_sched_pkg::row_t   cmd_row_o,
    output mem_sched_pkg::col_t   cmd_col_o,
    output mem_sched_pkg::bank_t  cmd_ba_o,
    output mem_sched_pkg::group_t cmd_bg_o,
    output logic                  cmd_hit_o
);

    mem_sched_pkg::bank_id_t                     bank_id;
    mem_sched_pkg::row_t                         open_row [mem_sched_pkg::N_SLOTS];
    logic                [mem_sched_pkg::N_SLOTS-1:0] open_vld;
    logic                                        row_hit;

    assign bank_id = {bg_i, ba_i};
    assign row_hit = open_vld[bank_id] && (open_row[bank_id] == row_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_o <= 1'b0;
            open_vld    <= '0;
        end else begin
            cmd_valid_o <= grant_i;
            if (grant_i) begin
                open_vld[bank_id] <= 1'b1;
            end
        end
    end

    // command fields and the open row of the issued bank
    always_ff @(posedge clk_i) begin
        if (grant_i) begin
            open_row[bank_id] <= row_i;
            cmd_data_o        <= data_i;
            cmd_idx_o         <= idx_i;
            cmd_row_o         <= row_i;
            cmd_col_o         <= col_i;
            cmd_ba_o          <= ba_i;
            cmd_bg_o          <= bg_i;
            cmd_hit_o         <= row_hit;
        end
    end

endmodule

/* verilog/mem_sched_top.sv */
module mem_sched_top #(
    parameter int BANK_GAP = 3
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  mem_sched_pkg::addr_t  req_addr_i,
    input  mem_sched_pkg::data_t  req_data_i,
    input  mem_sched_pkg::idx_t   req_idx_i,
    output logic                  drop_o,
    output logic                  cmd_valid_o,
    output mem_sched_pkg::data_t  cmd_data_o,
    output mem_sched_pkg::idx_t   cmd_idx_o,
    output mem_sched_pkg::row_t   cmd_row_o,
    output mem_sched_pkg::col_t   cmd_col_o,
    output mem_sched_pkg::bank_t  cmd_ba_o,
    output mem_sched_pkg::group_t cmd_bg_o,
    output logic                  cmd_hit_o
);

    logic                  [mem_sched_pkg::N_SLOTS-1:0]  pending;
    mem_sched_pkg::data_t  [mem_sched_pkg::N_SLOTS-1:0]  slot_data;
    mem_sched_pkg::idx_t   [mem_sched_pkg::N_SLOTS-1:0]  slot_idx;
    mem_sched_pkg::row_t   [mem_sched_pkg::N_SLOTS-1:0]  slot_row;
    mem_sched_pkg::col_t   [mem_sched_pkg::N_SLOTS-1:0]  slot_col;
    mem_sched_pkg::bank_t  [mem_sched_pkg::N_GROUPS-1:0] bank_sel;
    mem_sched_pkg::group_t                               group_sel;
    logic                                                grant;
    mem_sched_pkg::bank_id_t                             grant_bank;

    // fields of the granted slot
    mem_sched_pkg::data_t  sel_data;
    mem_sched_pkg::idx_t   sel_idx;
    mem_sched_pkg::row_t   sel_row;
    mem_sched_pkg::col_t   sel_col;
    mem_sched_pkg::bank_t  sel_ba;
    mem_sched_pkg::group_t sel_bg;

    req_decode i_req_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_data_i   (req_data_i),
        .req_idx_i    (req_idx_i),
        .grant_i      (grant),
        .grant_bank_i (grant_bank),
        .pending_o    (pending),
        .slot_data_o  (slot_data),
        .slot_idx_o   (slot_idx),
        .slot_row_o   (slot_row),
        .slot_col_o   (slot_col),
        .drop_o       (drop_o)
    );

    bank_arbiter #(
        .BANK_GAP (BANK_GAP)
    ) i_bank_arbiter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .pending_i    (pending),
        .bank_sel_o   (bank_sel),
        .group_sel_o  (group_sel),
        .grant_o      (grant),
        .grant_bank_o (grant_bank)
    );

    data_path i_data_path (
        .data_i      (slot_data),
        .idx_i       (slot_idx),
        .row_i       (slot_row),
        .col_i       (slot_col),
        .bank_sel_i  (bank_sel),
        .group_sel_i (group_sel),
        .data_o      (sel_data),
        .idx_o       (sel_idx),
        .row_o       (sel_row),
        .col_o       (sel_col),
        .ba_o        (sel_ba),
        .bg_o        (sel_bg)
    );

    cmd_issue i_cmd_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .grant_i     (grant),
        .data_i      (sel_data),
        .idx_i       (sel_idx),
        .row_i       (sel_row),
        .col_i       (sel_col),
        .ba_i        (sel_ba),
        .bg_i        (sel_bg),
        .cmd_valid_o (cmd_valid_o),
        .cmd_data_o  (cmd_data_o),
        .cmd_idx_o   (cmd_idx_o),
        .cmd_row_o   (cmd_row_o),
        .cmd_col_o   (cmd_col_o),
        .cmd_ba_o    (cmd_ba_o),
        .cmd_bg_o    (cmd_bg_o),
        .cmd_hit_o   (cmd_hit_o)
    );

endmodule

/* sim/tb_mem_sched.sv */
module tb_mem_sched;

    localparam int BANK_GAP = 3;
    localparam int N_RANDOM = 600;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    mem_sched_pkg::addr_t  req_addr;
    mem_sched_pkg::data_t  req_data;
    mem_sched_pkg::idx_t   req_idx;
    logic                  drop;
    logic                  cmd_valid;
    mem_sched_pkg::data_t  cmd_data;
    mem_sched_pkg::idx_t   cmd_idx;
    mem_sched_pkg::row_t   cmd_row;
    mem_sched_pkg::col_t   cmd_col;
    mem_sched_pkg::bank_t  cmd_ba;
    mem_sched_pkg::group_t cmd_bg;
    logic                  cmd_hit;

    // shadow of the request slots
    bit                   sh_vld  [16];
    mem_sched_pkg::data_t sh_data [16];
    mem_sched_pkg::idx_t  sh_idx  [16];
    mem_sched_pkg::row_t  sh_row  [16];
    mem_sched_pkg::col_t  sh_col  [16];
    int                   accept_cycle [16];

    // open rows in command order, and issue history per bank
    bit                   open_vld [16];
    mem_sched_pkg::row_t  open_row [16];
    bit                   issued [16];
    int                   last_issue [16];
    int                   issue_cnt [16];

    // small row pool so that row hits occur
    mem_sched_pkg::row_t  row_pool [4] = '{16'h0012, 16'h3a40, 16'hbeef, 16'h7001};

    // strobe that the next edge samples
    bit                   stb_vld;
    mem_sched_pkg::addr_t stb_addr;
    mem_sched_pkg::data_t stb_data;
    mem_sched_pkg::idx_t  stb_idx;

    int cycle;
    int n_cmd;
    int n_drop;
    int n_hit;
    int last_lat;
    int errors;

    mem_sched_top #(
        .BANK_GAP (BANK_GAP)
    ) i_mem_sched_top (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_addr_i  (req_addr),
        .req_data_i  (req_data),
        .req_idx_i   (req_idx),
        .drop_o      (drop),
        .cmd_valid_o (cmd_valid),
        .cmd_data_o  (cmd_data),
        .cmd_idx_o   (cmd_idx),
        .cmd_row_o   (cmd_row),
        .cmd_col_o   (cmd_col),
        .cmd_ba_o    (cmd_ba),
        .cmd_bg_o    (cmd_bg),
        .cmd_hit_o   (cmd_hit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_cmd(input mem_sched_pkg::data_t data, input mem_sched_pkg::idx_t idx,
                             input mem_sched_pkg::row_t row, input mem_sched_pkg::col_t col);
        if (cmd_data !== data || cmd_idx !== idx || cmd_row !== row || cmd_col !== col) begin
            errors++;
            $display(
                "[FAIL] t=%0t bg %0d ba %0d: data %h idx %h row %h col %h, expected %h %h %h %h",
                $time, cmd_bg, cmd_ba, cmd_data, cmd_idx, cmd_row, cmd_col,
                data, idx, row, col);
        end
    endtask

    task automatic check_hit(input bit exp);
        if (cmd_hit !== exp) begin
            errors++;
            $display("[FAIL] t=%0t bg %0d ba %0d: cmd_hit_o %b, expected %b",
                     $time, cmd_bg, cmd_ba, cmd_hit, exp);
        end
    endtask

    task automatic check_drop(input logic exp);
        if (drop !== exp) begin
            errors++;
            $display("[FAIL] t=%0t drop_o %b, expected %b", $time, drop, exp);
        end
    endtask

    task automatic score_cmd();
        mem_sched_pkg::bank_id_t b;
        bit                      hit;
        b = {cmd_bg, cmd_ba};
        n_cmd++;
        issue_cnt[b] = issue_cnt[b] + 1;
        if (!sh_vld[b]) begin
            errors++;
            $display("command at t=%0t for bank %0d, whose slot is empty", $time, b);
        end else begin
            check_cmd(sh_data[b], sh_idx[b], sh_row[b], sh_col[b]);
            hit = open_vld[b] && (open_row[b] == sh_row[b]);
            check_hit(hit);
            if (hit) begin
                n_hit++;
            end
            open_vld[b] = 1'b1;
            open_row[b] = sh_row[b];
            last_lat    = cycle - accept_cycle[b];
            sh_vld[b]   = 1'b0;
        end
        // a granted bank stays blocked for the next BANK_GAP cycles
        if (issued[b] && cycle - last_issue[b] <= BANK_GAP) begin
            errors++;
            $display("bank %0d issued again %0d cycles after its last command at t=%0t",
                     b, cycle - last_issue[b], $time);
        end
        issued[b]     = 1'b1;
        last_issue[b] = cycle;
    endtask

    // outputs of the last edge, against the inputs that edge sampled
    task automatic observe();
        mem_sched_pkg::bank_id_t b;
        logic                    accept;
        cycle++;
        if (cmd_valid) begin
            score_cmd();
        end
        if (drop) begin
            n_drop++;
        end
        if (stb_vld) begin
            // address from the top: row 16, bank 2, group 2, column 10
            b      = {stb_addr[11:10], stb_addr[13:12]};
            accept = !sh_vld[b] && !(cmd_valid && ({cmd_bg, cmd_ba} == b));
            check_drop(!accept);
            if (accept) begin
                sh_vld[b]       = 1'b1;
                sh_row[b]       = stb_addr[29:14];
                sh_col[b]       = stb_addr[9:0];
                sh_data[b]      = stb_data;
                sh_idx[b]       = stb_idx;
                accept_cycle[b] = cycle;
            end
        end else begin
            check_drop(1'b0);
        end
        stb_vld  = req_valid;
        stb_addr = req_addr;
        stb_data = req_data;
        stb_idx  = req_idx;
    endtask

    task automatic tick();
        @(negedge clk);
        observe();
        @(posedge clk);
    endtask

    task automatic drive_req(input mem_sched_pkg::group_t g, input mem_sched_pkg::bank_t b,
                             input mem_sched_pkg::row_t row, input mem_sched_pkg::col_t col,
                             input mem_sched_pkg::data_t data, input mem_sched_pkg::idx_t idx);
        req_valid <= 1'b1;
        req_addr  <= {row, b, g, col};
        req_data  <= data;
        req_idx   <= idx;
        tick();
    endtask

    task automatic rand_req();
        logic [1:0] rsel;
        rsel = 2'($urandom);
        drive_req(mem_sched_pkg::group_t'($urandom), mem_sched_pkg::bank_t'($urandom),
                  row_pool[rsel], mem_sched_pkg::col_t'($urandom),
                  mem_sched_pkg::data_t'($urandom), mem_sched_pkg::idx_t'($urandom));
    endtask

    task automatic idle_cycle();
        req_valid <= 1'b0;
        tick();
    endtask

    function automatic int occupied();
        int n;
        n = 0;
        for (int k = 0; k < 16; k++) begin
            n += sh_vld[k];
        end
        return n;
    endfunction

    task automatic drain(input int limit);
        int n;
        n = 0;
        req_valid <= 1'b0;
        // the last strobe reaches the model two edges later
        repeat (2) tick();
        while (occupied() != 0 && n < limit) begin
            tick();
            n++;
        end
        if (occupied() != 0) begin
            errors++;
            $display("timeout: %0d slots still pending after %0d cycles", occupied(), limit);
        end
    endtask

    task automatic report(input string name, input int fails);
        $display("%-16s %0d failures", name, fails);
    endtask

    initial begin
        int                   seed_ret;
        int                   fails;
        int                   n;
        int                   n0;
        int                   d0;
        mem_sched_pkg::data_t a_data;
        mem_sched_pkg::idx_t  a_idx;
        mem_sched_pkg::col_t  a_col;
        seed_ret  = $urandom(32'h34d1dc57);
        rst       <= 1'b1;
        req_valid <= 1'b0;
        req_addr  <= '0;
        req_data  <= '0;
        req_idx   <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fails = errors;
        for (int k = 0; k < N_RANDOM; k++) begin
            if ($urandom % 3 != 0) begin
                rand_req();
            end else begin
                idle_cycle();
            end
        end
        drain(64);
        if (n_hit == 0) begin
            errors++;
            $display("no row hit seen during random traffic");
        end
        report("random traffic", errors - fails);

        // second strobe hits the still occupied slot
        repeat (BANK_GAP + 2) tick();
        fails  = errors;
        n0     = n_cmd;
        d0     = n_drop;
        a_data = mem_sched_pkg::data_t'($urandom);
        a_idx  = mem_sched_pkg::idx_t'($urandom);
        a_col  = mem_sched_pkg::col_t'($urandom);
        drive_req(2'd1, 2'd2, row_pool[0], a_col, a_data, a_idx);
        drive_req(2'd1, 2'd2, row_pool[1], ~a_col, ~a_data, ~a_idx);
        drain(16);
        if (n_drop - d0 != 1 || n_cmd - n0 != 1) begin
            errors++;
            $display("drop test saw %0d drops and %0d commands instead of one each",
                     n_drop - d0, n_cmd - n0);
        end
        check_cmd(a_data, a_idx, row_pool[0], a_col);
        report("drop", errors - fails);

        repeat (BANK_GAP + 2) tick();
        fails = errors;
        n0    = n_cmd;
        d0    = n_drop;
        for (int k = 0; k < 16; k++) begin
            issue_cnt[k] = 0;
        end
        for (int s = 0; s < 16; s++) begin
            drive_req(mem_sched_pkg::group_t'(s / 4), mem_sched_pkg::bank_t'(s % 4),
                      row_pool[s % 4], mem_sched_pkg::col_t'($urandom),
                      mem_sched_pkg::data_t'($urandom), mem_sched_pkg::idx_t'(s));
        end
        req_valid <= 1'b0;
        n = 16;
        while (n_cmd - n0 < 16 && n < 64) begin
            tick();
            n++;
        end
        if (n_cmd - n0 < 16) begin
            errors++;
            $display("timeout: only %0d of 16 banks issued within 64 cycles", n_cmd - n0);
        end
        drain(8);
        for (int k = 0; k < 16; k++) begin
            if (issue_cnt[k] != 1) begin
                errors++;
                $display("bank %0d issued %0d times after filling all slots", k, issue_cnt[k]);
            end
        end
        if (n_drop != d0) begin
            errors++;
            $display("requests to empty slots were dropped");
        end
        report("fill all banks", errors - fails);

        repeat (BANK_GAP + 2) tick();
        fails = errors;
        n0    = n_cmd;
        drive_req(2'd3, 2'd0, row_pool[2], mem_sched_pkg::col_t'($urandom),
                  mem_sched_pkg::data_t'($urandom), mem_sched_pkg::idx_t'($urandom));
        req_valid <= 1'b0;
        n = 0;
        while (n_cmd == n0 && n < 16) begin
            tick();
            n++;
        end
        if (n_cmd == n0) begin
            errors++;
            $display("timeout: no command within 16 cycles of a single request");
        end else if (last_lat != 2) begin
            errors++;
            $display("[FAIL] t=%0t latency %0d cycles, expected 2", $time, last_lat);
        end
        report("isolated latency", errors - fails);

        $display("commands %0d, drops %0d, row hits %0d, failures %0d",
                 n_cmd, n_drop, n_hit, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/mem_sched_pkg.sv
verilog/req_decode.sv
verilog/bank_arbiter.sv
verilog/data_path.sv
verilog/cmd_issue.sv
verilog/mem_sched_top.sv
sim/tb_mem_sched.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_mem_sched \
    -f flist.f \
    -o sim_mem_sched

./obj_dir/sim_mem_sched > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
